//--- design/cpu_macros.svh
// Widths, slot length and opcode codes. Opcode macros are sized to OPCODE_WIDTH by hand
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////
`define DATA_WIDTH      8
`define REG_ADDR_WIDTH  4
`define NUM_REGS        16     // One entry per REG_ADDR_WIDTH code
`define OPCODE_WIDTH    5
`define IMM_WIDTH       9
`define SLOT_CYCLES     8      // T0..T4 plus three idle cycles

////////////////////////////////////////
// ALU opcodes
////////////////////////////////////////
`define OP_ADD       5'd0
`define OP_SUB       5'd1
`define OP_AND       5'd2
`define OP_OR        5'd3
`define OP_XOR       5'd4
`define OP_SHL       5'd5
`define OP_SHR       5'd6
`define OP_NOT       5'd7
`define OP_LESS      5'd8
`define OP_LAST_ALU  5'd8      // Anything above is a no-op

`endif

//--- design/cpuPkg.sv
// Types for the execution core. instrT field order is opcode first and immFlag last
`include "cpu_macros.svh"

package cpuPkg;

  ////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////
  typedef logic [`DATA_WIDTH-1:0]     dataT;
  typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;
  typedef logic [`OPCODE_WIDTH-1:0]   opcodeT;
  typedef logic [`IMM_WIDTH-1:0]      immT;

  // Phases of one instruction slot
  typedef enum logic [$clog2(`SLOT_CYCLES)-1:0] {
    T0,
    T1,
    T2,
    T3,
    T4,
    Idle5,
    Idle6,
    Idle7
  } phaseE;

  // Instruction word as presented at the core input
  typedef struct packed {
    opcodeT  opcode;
    regAddrT destin;
    regAddrT source1;
    regAddrT source2;
    immT     imm;
    logic    immFlag;     // Operand 2 taken from imm
  } instrT;

  // Strobes plus the latched fields the datapath reads
  typedef struct packed {
    logic    regRead;
    logic    aluSave;     // Also saves both flags
    logic    regWrite;
    opcodeT  opcode;
    regAddrT destin;
    regAddrT source1;
    regAddrT source2;
    immT     imm;
    logic    immFlag;
  } ctrlT;

endpackage

//--- design/phaseSequencer.sv
// Phases free-run from Reset with no back-pressure. instr must be stable for the whole T0
`timescale 1ns/1ps
`include "cpu_macros.svh"

module phaseSequencer import cpuPkg::*; (
  input  logic  clk,
  input  logic  Reset,
  input  instrT instr,
  output logic  instrRead,
  output ctrlT  ctrl
);

  phaseE phase;
  phaseE phaseNext;
  instrT instrReg;
  logic  isAluOp;

  ////////////////////////////////////////
  // Phase counter
  ////////////////////////////////////////
  always_comb begin
    if (phase == phaseE'(`SLOT_CYCLES - 1)) begin
      phaseNext = T0;                      // Wrap after Idle7
    end else begin
      phaseNext = phaseE'(phase + 1'b1);
    end
  end

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      phase <= T0;                         // First slot starts right after reset
    end else begin
      phase <= phaseNext;
    end
  end

  ////////////////////////////////////////
  // Instruction register
  ////////////////////////////////////////
  assign instrRead = (phase == T0);

  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      instrReg <= '0;
    end else if (instrRead) begin
      instrReg <= instr;                   // Taken on the edge ending T0
    end
  end

  ////////////////////////////////////////
  // Strobe decode
  ////////////////////////////////////////
  assign isAluOp = (instrReg.opcode <= `OP_LAST_ALU);

  always_comb begin
    ctrl.regRead  = (phase == T1);         // Every opcode reads
    ctrl.aluSave  = (phase == T2) && isAluOp;
    ctrl.regWrite = (phase == T4) && isAluOp;
    ctrl.opcode   = instrReg.opcode;
    ctrl.destin   = instrReg.destin;
    ctrl.source1  = instrReg.source1;
    ctrl.source2  = instrReg.source2;
    ctrl.imm      = instrReg.imm;
    ctrl.immFlag  = instrReg.immFlag;
  end

endmodule

//--- design/registerFile.sv
// Registers clear on Reset. Read data is registered on regRead and holds until the next read
`timescale 1ns/1ps
`include "cpu_macros.svh"

module registerFile import cpuPkg::*; (
  input  logic clk,
  input  logic Reset,
  input  ctrlT ctrl,
  input  dataT wrData,
  output dataT rdData1,
  output dataT rdData2
);

  dataT regs [`NUM_REGS];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.regWrite) begin
      regs[ctrl.destin] <= wrData;         // Lands at end of T4
    end
  end

  ////////////////////////////////////////
  // Registered read ports
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      rdData1 <= '0;
      rdData2 <= '0;
    end else if (ctrl.regRead) begin
      rdData1 <= regs[ctrl.source1];       // Sampled at end of T1
      rdData2 <= regs[ctrl.source2];
    end
  end

endmodule

//--- design/aluUnit.sv
// Opcode validity is not checked here. aluSave only fires for opcodes up to OP_LAST_ALU
`timescale 1ns/1ps
`include "cpu_macros.svh"

module aluUnit import cpuPkg::*; (
  input  logic clk,
  input  logic Reset,
  input  ctrlT ctrl,
  input  dataT rdData1,
  input  dataT rdData2,
  output dataT aluResult,
  output logic zFlag,
  output logic cFlag
);

  dataT                 opA;
  dataT                 opB;
  logic [`DATA_WIDTH:0] result;            // Top bit is carry or borrow
  dataT                 resultLow;

  ////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////
  assign opA = rdData1;
  assign opB = ctrl.immFlag ? ctrl.imm[`DATA_WIDTH-1:0] : rdData2;

  ////////////////////////////////////////
  // Operations
  ////////////////////////////////////////
  always_comb begin
    case (ctrl.opcode)
      `OP_ADD:  result = {1'b0, opA} + {1'b0, opB};
      `OP_SUB:  result = {1'b0, opA} - {1'b0, opB};       // Borrow in top bit
      `OP_AND:  result = {1'b0, opA & opB};
      `OP_OR:   result = {1'b0, opA | opB};
      `OP_XOR:  result = {1'b0, opA ^ opB};
      `OP_SHL:  result = {opA, 1'b0};                     // Old MSB out as carry
      `OP_SHR:  result = {2'b00, opA[`DATA_WIDTH-1:1]};  // Zero fill
      `OP_NOT:  result = {1'b0, ~opA};
      `OP_LESS: result = {{`DATA_WIDTH{1'b0}}, (opA < opB)};  // Unsigned compare
      default:  result = '0;
    endcase
  end

  assign resultLow = result[`DATA_WIDTH-1:0];

  ////////////////////////////////////////
  // Result and flag registers
  ////////////////////////////////////////
  always_ff @(posedge clk or posedge Reset) begin
    if (Reset) begin
      aluResult <= '0;
      zFlag     <= 1'b0;
      cFlag     <= 1'b0;
    end else if (ctrl.aluSave) begin
      aluResult <= resultLow;              // Saved at end of T2
      zFlag     <= (resultLow == '0);
      cFlag     <= result[`DATA_WIDTH];
    end
  end

endmodule

//--- design/execCore.sv
// One instruction in flight per eight-cycle slot. The result is written back from aluResult
`timescale 1ns/1ps

module execCore import cpuPkg::*; (
  input  logic  clk,
  input  logic  Reset,
  input  instrT instr,
  output logic  instrRead,
  output dataT  aluResult,
  output logic  zFlag,
  output logic  cFlag
);

  ctrlT ctrl;
  dataT rdData1;
  dataT rdData2;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////
  phaseSequencer seq0 (
    .clk       (clk),
    .Reset     (Reset),
    .instr     (instr),
    .instrRead (instrRead),
    .ctrl      (ctrl)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////
  registerFile regs0 (
    .clk     (clk),
    .Reset   (Reset),
    .ctrl    (ctrl),
    .wrData  (aluResult),                  // Writeback in T4
    .rdData1 (rdData1),
    .rdData2 (rdData2)
  );

  aluUnit alu0 (
    .clk       (clk),
    .Reset     (Reset),
    .ctrl      (ctrl),
    .rdData1   (rdData1),
    .rdData2   (rdData2),
    .aluResult (aluResult),
    .zFlag     (zFlag),
    .cFlag     (cFlag)
  );

endmodule

//--- tests/clockGen.sv
// Free-running 10 ns clock. Reset is high from time zero and drops on a falling edge
`timescale 1ns/1ps

module clockGen #(
  parameter int halfPeriod  = 5,
  parameter int resetCycles = 16
) (
  output logic clk,
  output logic Reset
);

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

  initial begin
    Reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    Reset = 1'b0;                          // Away from the active edge
  end

endmodule

//--- tests/execCoreTb.sv
// One instruction per slot. Each slot is checked at the next T0, and the last one by a drain slot
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execCoreTb import cpuPkg::*; ();

  localparam int resetLimit = 40;
  localparam int readLimit  = 2 * `SLOT_CYCLES;

  logic  clk;
  logic  Reset;
  instrT instr;
  logic  instrRead;
  dataT  aluResult;
  logic  zFlag;
  logic  cFlag;

  integer seed         = 20656;
  int     errorCount   = 0;
  int     checkCount   = 0;
  int     timeoutCount = 0;
  bit     aborted      = 1'b0;
  bit     readSeen     = 1'b0;

  // Reference model state
  dataT   modelRegs [`NUM_REGS];
  dataT   modelResult;
  logic   modelZ;
  logic   modelC;
  string  pendingName;
  bit     pendingValid;

  clockGen clk0 (
    .clk   (clk),
    .Reset (Reset)
  );

  execCore dut0 (
    .clk       (clk),
    .Reset     (Reset),
    .instr     (instr),
    .instrRead (instrRead),
    .aluResult (aluResult),
    .zFlag     (zFlag),
    .cFlag     (cFlag)
  );

  ////////////////////////////////////////
  // Instruction builders
  ////////////////////////////////////////
  function automatic instrT makeInstr(opcodeT op, regAddrT dst, regAddrT src1,
                                      regAddrT src2, immT imm, logic useImm);
    instrT i;
    i.opcode  = op;
    i.destin  = dst;
    i.source1 = src1;
    i.source2 = src2;
    i.imm     = imm;
    i.immFlag = useImm;
    return i;
  endfunction

  function automatic instrT randomInstr(opcodeT op);
    logic [31:0] r;
    instrT       i;
    r = $random(seed);
    i = r[$bits(instrT)-1:0];              // All other fields random
    i.opcode = op;
    return i;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  task automatic modelExecute(instrT i);
    dataT a;
    dataT b;
    if (i.opcode > `OP_LAST_ALU) begin
      return;                              // No-op slot
    end
    a = modelRegs[i.source1];
    b = i.immFlag ? i.imm[7:0] : modelRegs[i.source2];
    modelC = 1'b0;
    case (i.opcode)
      `OP_ADD: begin
        modelResult = a + b;
        modelC      = (int'(a) + int'(b)) > 255;
      end
      `OP_SUB: begin
        modelResult = a - b;
        modelC      = (a < b);             // Borrow
      end
      `OP_AND:  modelResult = a & b;
      `OP_OR:   modelResult = a | b;
      `OP_XOR:  modelResult = a ^ b;
      `OP_SHL: begin
        modelResult = {a[6:0], 1'b0};
        modelC      = a[7];
      end
      `OP_SHR:  modelResult = {1'b0, a[7:1]};
      `OP_NOT:  modelResult = ~a;
      `OP_LESS: modelResult = (a < b) ? 8'd1 : 8'd0;
      default: ;
    endcase
    modelZ = (modelResult == 8'd0);
    modelRegs[i.destin] = modelResult;     // Lands after this slot's read
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic checkValue(string testName, string what, logic [31:0] expVal,
                            logic [31:0] actVal);
    checkCount++;
    assert (actVal === expVal) else begin
      errorCount++;
      $display("FAIL %s: %s expected 0x%0h, actual 0x%0h", testName, what, expVal, actVal);
    end
  endtask

  task automatic compareOutputs(string testName);
    checkValue(testName, "aluResult", 32'(modelResult), 32'(aluResult));
    checkValue(testName, "zFlag", 32'(modelZ), 32'(zFlag));
    checkValue(testName, "cFlag", 32'(modelC), 32'(cFlag));
  endtask

  ////////////////////////////////////////
  // Slot driving
  ////////////////////////////////////////
  task automatic waitForRead();
    int waited;
    waited = 0;
    if (aborted) begin
      return;
    end
    do begin
      @(negedge clk);
      waited++;
    end while (!instrRead && waited < readLimit);
    if (!instrRead) begin
      timeoutCount++;
      aborted = 1'b1;
      $display("Timeout: instrRead did not go high within %0d cycles", readLimit);
      return;
    end
    if (readSeen) begin
      checkValue("slot timing", "cycles between reads", 32'(`SLOT_CYCLES), 32'(waited));
    end
    readSeen = 1'b1;
  endtask

  task automatic runSlot(instrT nextInstr, string testName);
    waitForRead();
    if (aborted) begin
      return;
    end
    if (pendingValid) begin
      compareOutputs(pendingName);         // Previous slot is complete here
    end
    instr = nextInstr;                     // Held through this T0
    modelExecute(nextInstr);
    pendingName  = testName;
    pendingValid = 1'b1;
  endtask

  task automatic drainSlot();
    waitForRead();
    if (!aborted && pendingValid) begin
      compareOutputs(pendingName);
    end
    pendingValid = 1'b0;
  endtask

  task automatic loadValue(regAddrT dst, dataT value, string testName);
    runSlot(makeInstr(`OP_AND, dst, dst, '0, '0, 1'b1), testName);
    runSlot(makeInstr(`OP_OR, dst, dst, '0, immT'(value), 1'b1), testName);
  endtask

  task automatic readAllRegs(string testName);
    for (int k = 0; k < `NUM_REGS; k++) begin
      runSlot(makeInstr(`OP_OR, regAddrT'(k), regAddrT'(k), '0, '0, 1'b1), testName);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    int          waited;
    instrT       cur;
    logic [31:0] r;
    regAddrT     dst;
    instr = makeInstr(5'd31, '0, '0, '0, '0, 1'b0);   // First slot is a no-op
    for (int k = 0; k < `NUM_REGS; k++) begin
      modelRegs[k] = '0;
    end
    modelResult  = '0;
    modelZ       = 1'b0;
    modelC       = 1'b0;
    pendingValid = 1'b0;

    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (Reset !== 1'b0 && waited < resetLimit);
    if (Reset !== 1'b0) begin
      timeoutCount++;
      aborted = 1'b1;
      $display("Timeout: Reset was still high after %0d cycles", resetLimit);
    end else begin
      @(negedge clk);
      compareOutputs("reset");
    end

    // Immediate loads, r15 loaded last so it reads as zero throughout
    for (int k = 0; k < `NUM_REGS; k++) begin
      r = $random(seed);
      cur = makeInstr(`OP_ADD, regAddrT'(k), regAddrT'(`NUM_REGS - 1), '0, immT'(r), 1'b1);
      runSlot(cur, "immediate load");
    end
    readAllRegs("immediate readback");

    for (int k = 0; k < 200; k++) begin
      r = $random(seed);
      runSlot(randomInstr(opcodeT'(r % 32'd9)), "random op");
    end

    // Directed carry, borrow and compare
    loadValue(4'd1, 8'd200, "directed load");
    loadValue(4'd2, 8'd100, "directed load");
    runSlot(makeInstr(`OP_ADD, 4'd3, 4'd1, 4'd2, '0, 1'b0), "add overflow");
    runSlot(makeInstr(`OP_ADD, 4'd8, 4'd1, '0, 9'd56, 1'b1), "add wraps to zero");
    runSlot(makeInstr(`OP_SUB, 4'd4, 4'd2, 4'd1, '0, 1'b0), "subtract borrow");
    runSlot(makeInstr(`OP_SHL, 4'd5, 4'd1, '0, '0, 1'b0), "shift-left carry");
    runSlot(makeInstr(`OP_XOR, 4'd6, 4'd1, 4'd1, '0, 1'b0), "zero result");
    runSlot(makeInstr(`OP_LESS, 4'd7, 4'd2, 4'd1, '0, 1'b0), "less true");
    runSlot(makeInstr(`OP_LESS, 4'd7, 4'd1, 4'd2, '0, 1'b0), "less false");

    // Nonzero result with carry set ahead of the no-ops
    runSlot(makeInstr(`OP_SHL, 4'd9, 4'd1, '0, '0, 1'b0), "shift-left carry");

    for (int k = 0; k < 20; k++) begin
      r = $random(seed);
      runSlot(randomInstr(opcodeT'(32'd9 + r % 32'd23)), "no-op");
    end
    readAllRegs("no-op readback");

    for (int k = 0; k < 30; k++) begin
      r = $random(seed);
      cur = randomInstr(opcodeT'(r % 32'd9));
      dst = cur.destin;
      runSlot(cur, "write before read");
      r = $random(seed);
      cur = randomInstr(opcodeT'(r % 32'd9));
      cur.source1 = dst;                   // Depends on the previous write
      runSlot(cur, "read after write");
    end

    drainSlot();
    $display("Checks: %0d  Errors: %0d  Timeouts: %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+design
design/cpuPkg.sv
design/phaseSequencer.sv
design/registerFile.sv
design/aluUnit.sv
design/execCore.sv
tests/clockGen.sv
tests/execCoreTb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the execCore testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module execCoreTb -o execCoreSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/execCoreSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
exit 0
